//--- build.f
+incdir+testbench
common/uartPkg.sv
uartRx/uartRx.sv
uartRx/rxFifo.sv
rtl/channelMerger.sv
rtl/uartHub.sv
testbench/uartHubTb.sv

//--- run.sh
#!/bin/sh
# Compile the uartHub testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module uartHubTb -o uartHubSim \
	&& ./obj_dir/uartHubSim | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

//--- testbench/uartHubTests.svh
`default_nettype none

//////////////////////////////////////////////////
// Directed tests.
//////////////////////////////////////////////////

// One byte on channel 0 gives one clean word.
task automatic singleByte();
	logic [7:0] data;
	startTest();
	data = 8'($urandom());
	sendFrame0(data, 1'b0);
	waitWords(1, 200);
	settle(100);
	checkValue("word count", 1, received.size());
	checkWord(0, 1'b0, data, 1'b0);
	reportTest("single byte");
endtask

// Both lines at once, order between channels is free.
task automatic concurrentChannels();
	logic [7:0] data0;
	logic [7:0] data1;
	int hits0;
	int hits1;
	int i;
	startTest();
	data0 = 8'($urandom());
	// Nonzero offset keeps the two bytes apart.
	data1 = data0 + 8'($urandom_range(255, 1));
	hits0 = 0;
	hits1 = 0;
	fork
		sendFrame0(data0, 1'b0);
		sendFrame1(data1, 1'b0);
	join
	waitWords(2, 200);
	settle(100);
	checkValue("word count", 2, received.size());
	for (i = 0; i < received.size(); i++) begin
		if (received[i].channel) begin
			hits1++;
			checkWord(i, 1'b1, data1, 1'b0);
		end else begin
			hits0++;
			checkWord(i, 1'b0, data0, 1'b0);
		end
	end
	checkValue("channel 0 words", 1, hits0);
	checkValue("channel 1 words", 1, hits1);
	reportTest("concurrent channels");
endtask

// Low stop bit still delivers the data, flagged.
task automatic framingErrorFrame();
	logic [7:0] data;
	startTest();
	data = 8'($urandom());
	sendFrame1(data, 1'b1);
	waitWords(1, 200);
	settle(100);
	checkValue("word count", 1, received.size());
	checkWord(0, 1'b1, data, 1'b1);
	reportTest("framing error");
endtask

// Four credits let four words out; the rest wait in the queue.
task automatic creditBackPressure();
	logic [7:0] sent [6];
	int i;
	startTest();
	setHold(1'b1);
	for (i = 0; i < 6; i++) begin
		sent[i] = 8'($urandom());
		sendFrame1(sent[i], 1'b0);
	end
	waitWords(4, 200);
	settle(100);
	checkValue("held word count", 4, received.size());
	setHold(1'b0);
	waitWords(6, 300);
	settle(100);
	checkValue("word count", 6, received.size());
	for (i = 0; i < 6; i++) begin
		checkWord(i, 1'b1, sent[i], 1'b0);
	end
	checkValue("overflow", 0, overflow);
	reportTest("credit back-pressure");
endtask

// Queue of four plus one more byte, the fifth is dropped.
task automatic queueOverflow();
	logic [7:0] sent [5];
	int i;
	startTest();
	setHold(1'b1);
	// Use up every credit first.
	for (i = 0; i < 4; i++) begin
		sendFrame0(8'($urandom()), 1'b0);
	end
	waitWords(4, 200);
	for (i = 0; i < 5; i++) begin
		sent[i] = 8'($urandom());
		sendFrame0(sent[i], 1'b0);
	end
	settle(10);
	checkValue("overflow[0]", 1, overflow[0]);
	checkValue("overflow[1]", 0, overflow[1]);
	setHold(1'b0);
	waitWords(8, 300);
	settle(100);
	checkValue("word count", 8, received.size());
	for (i = 0; i < 4; i++) begin
		checkWord(4 + i, 1'b0, sent[i], 1'b0);
	end
	reportTest("overflow");
endtask

// Quarter bit low pulse is not a start bit.
task automatic glitchRejection();
	startTest();
	@(posedge clk);
	rx[1] <= 1'b0;
	repeat (4) @(posedge clk);
	rx[1] <= 1'b1;
	// Two frame times.
	settle(320);
	checkValue("word count", 0, received.size());
	reportTest("glitch rejection");
endtask

`default_nettype wire

//--- testbench/uartHubTb.sv
`timescale 1ns/10ps
`default_nettype none

module uartHubTb;
	import uartPkg::*;

	logic clk = 1'b0;
	logic rst;
	logic [CLOCK_SCALE_BITS-1:0] cyclesPerBit;
	logic [NUM_CHANNELS-1:0] rx;
	logic creditReturn = 1'b0;
	hubWord_t outWord;
	logic outValid;
	logic [NUM_CHANNELS-1:0] overflow;

	// Consumer side state.
	hubWord_t received[$];
	int owed;
	int returnDelay;
	bit holdCredits;
	// Bookkeeping for the report.
	int errorCount;
	int testStartErrors;
	int testsRun;
	int testsFailed;

	// 100 ns clock.
	always #50 clk = !clk;

	uartHub dut0 (
		.clk(clk), .rst(rst), .cyclesPerBit(cyclesPerBit), .rx(rx),
		.creditReturn(creditReturn), .outWord(outWord), .outValid(outValid),
		.overflow(overflow)
	);

	//////////////////////////////////////////////////
	// Consumer model.
	//////////////////////////////////////////////////

	// Logs every word and hands its credit back a few cycles later.
	always @(posedge clk) begin
		if (rst) begin
			creditReturn <= 1'b0;
			owed = 0;
			returnDelay = 0;
		end else begin
			creditReturn <= 1'b0;
			if (outValid) begin
				received.push_back(outWord);
				owed = owed + 1;
			end
			// Never more returns than words seen.
			if (!holdCredits && owed > 0) begin
				if (returnDelay == 3) begin
					creditReturn <= 1'b1;
					owed = owed - 1;
					returnDelay = 0;
				end else begin
					returnDelay = returnDelay + 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Serial drivers and checks.
	//////////////////////////////////////////////////

	// Start bit, eight data bits LSB first, stop bit, then idle line.
	task automatic sendFrame0(input logic [7:0] data, input logic lowStop);
		logic [9:0] frame;
		int i;
		frame = {!lowStop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rx[0] <= frame[i];
			repeat (15) @(posedge clk);
		end
		@(posedge clk);
		rx[0] <= 1'b1;
		repeat (32) @(posedge clk);
	endtask

	// Same frame on the second line.
	task automatic sendFrame1(input logic [7:0] data, input logic lowStop);
		logic [9:0] frame;
		int i;
		frame = {!lowStop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rx[1] <= frame[i];
			repeat (15) @(posedge clk);
		end
		@(posedge clk);
		rx[1] <= 1'b1;
		repeat (32) @(posedge clk);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			errorCount++;
		end
	endtask

	// Compares one logged word field by field.
	task automatic checkWord(input int index, input logic channel,
			input logic [7:0] data, input logic framingError);
		if (index >= received.size()) begin
			$display("Word %0d never reached the consumer", index);
			errorCount++;
		end else begin
			checkValue("outWord.channel", channel, received[index].channel);
			checkValue("outWord.data", data, received[index].data);
			checkValue("outWord.framingError", framingError, received[index].framingError);
		end
	endtask

	// Waits on the falling edge, where everything has settled.
	task automatic waitWords(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (received.size() < count && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (received.size() < count) begin
			$display("Timed out with %0d of %0d words received", received.size(), count);
			errorCount++;
		end
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	task automatic setHold(input bit value);
		@(negedge clk);
		holdCredits = value;
	endtask

	// All credits back in the merger, then a clean log.
	task automatic startTest();
		int cycles;
		cycles = 0;
		while ((owed != 0 || creditReturn) && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (owed != 0 || creditReturn) begin
			$display("Timed out waiting for credits to return");
			errorCount++;
		end
		received.delete();
		testStartErrors = errorCount;
	endtask

	function automatic void reportTest(input string name);
		testsRun++;
		if (errorCount == testStartErrors) begin
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: %0d errors", name, errorCount - testStartErrors);
		end
	endfunction

	initial begin
		void'($urandom(16253));
		rst = 1'b1;
		rx = '1;
		// 16 clocks per bit.
		cyclesPerBit = 16'd15;
		holdCredits = 1'b0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		singleByte();
		concurrentChannels();
		framingErrorFrame();
		creditBackPressure();
		queueOverflow();
		glitchRejection();
		$display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

`include "uartHubTests.svh"

endmodule

`default_nettype wire

//--- rtl/uartHub.sv
`timescale 1ns/10ps
`default_nettype none

module uartHub (
	input wire clk,
	input wire rst,
	input wire [uartPkg::CLOCK_SCALE_BITS-1:0] cyclesPerBit,
	input wire [uartPkg::NUM_CHANNELS-1:0] rx,
	input wire creditReturn,
	output uartPkg::hubWord_t outWord,
	output logic outValid,
	output logic [uartPkg::NUM_CHANNELS-1:0] overflow
);
	import uartPkg::*;

	// Receiver to queue.
	rxByte_t rxByte0, rxByte1;
	logic byteValid0, byteValid1;
	// Queue heads to merger.
	rxByte_t headByte0, headByte1;
	logic notEmpty0, notEmpty1;
	logic pop0, pop1;

	//////////////////////////////////////////////////
	// Channel 0.
	//////////////////////////////////////////////////

	uartRx rx0 (
		.clk(clk), .rst(rst), .cyclesPerBit(cyclesPerBit), .rx(rx[0]),
		.rxByte(rxByte0), .byteValid(byteValid0)
	);

	rxFifo #(.depth(FIFO_DEPTH)) fifo0 (
		.clk(clk), .rst(rst), .writeByte(rxByte0), .write(byteValid0),
		.pop(pop0), .headByte(headByte0), .notEmpty(notEmpty0),
		.overflow(overflow[0])
	);

	//////////////////////////////////////////////////
	// Channel 1.
	//////////////////////////////////////////////////

	uartRx rx1 (
		.clk(clk), .rst(rst), .cyclesPerBit(cyclesPerBit), .rx(rx[1]),
		.rxByte(rxByte1), .byteValid(byteValid1)
	);

	rxFifo #(.depth(FIFO_DEPTH)) fifo1 (
		.clk(clk), .rst(rst), .writeByte(rxByte1), .write(byteValid1),
		.pop(pop1), .headByte(headByte1), .notEmpty(notEmpty1),
		.overflow(overflow[1])
	);

	// Round robin towards the consumer.
	channelMerger merger0 (
		.clk(clk), .rst(rst),
		.headByte0(headByte0), .headByte1(headByte1),
		.notEmpty0(notEmpty0), .notEmpty1(notEmpty1),
		.pop0(pop0), .pop1(pop1),
		.creditReturn(creditReturn),
		.outWord(outWord), .outValid(outValid)
	);

endmodule

`default_nettype wire

//--- rtl/channelMerger.sv
`timescale 1ns/10ps
`default_nettype none

module channelMerger (
	input wire clk,
	input wire rst,
	input wire uartPkg::rxByte_t headByte0,
	input wire uartPkg::rxByte_t headByte1,
	input wire notEmpty0,
	input wire notEmpty1,
	output logic pop0,
	output logic pop1,
	// One pulse gives back one credit.
	input wire creditReturn,
	output uartPkg::hubWord_t outWord,
	output logic outValid
);
	import uartPkg::*;

	logic [CREDIT_BITS-1:0] credits;
	// Channel preferred when both queues hold data.
	logic rrNext;
	logic pick;
	logic anyReady;
	logic hasCredit;
	logic send;
	rxByte_t picked;

	//////////////////////////////////////////////////
	// Channel selection.
	//////////////////////////////////////////////////

	assign anyReady = notEmpty0 || notEmpty1;
	assign hasCredit = (credits != '0);
	assign send = anyReady && hasCredit;

	// Round robin on contention, otherwise whichever has data.
	always_comb begin
		if (notEmpty0 && notEmpty1) begin
			pick = rrNext;
		end else begin
			pick = notEmpty1;
		end
	end

	assign picked = pick ? headByte1 : headByte0;

	// Pop only the queue we take from.
	assign pop0 = send && !pick;
	assign pop1 = send && pick;

	//////////////////////////////////////////////////
	// Credits and output register.
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			rrNext <= 1'b0;
			credits <= CREDIT_BITS'(MAX_CREDITS);
		end else begin
			outValid <= send;
			// Hand priority to the other channel.
			if (send) begin
				rrNext <= !pick;
			end
			// Send and return together cancel out.
			case ({send, creditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Tagged word.
	always_ff @(posedge clk) begin
		if (send) begin
			outWord.channel <= pick;
			outWord.data <= picked.data;
			outWord.framingError <= picked.framingError;
		end
	end

	// Consumer must not return more than it received.
	creditLimit: assert property (@(posedge clk) disable iff (rst)
		int'(credits) <= MAX_CREDITS)
		else $error("credit count above limit");

endmodule

`default_nettype wire

//--- uartRx/rxFifo.sv
`timescale 1ns/10ps
`default_nettype none

module rxFifo #(
	parameter int depth = uartPkg::FIFO_DEPTH
) (
	input wire clk,
	input wire rst,
	input wire uartPkg::rxByte_t writeByte,
	input wire write,
	input wire pop,
	output uartPkg::rxByte_t headByte,
	output logic notEmpty,
	output logic overflow
);
	import uartPkg::*;

	rxByte_t mem [depth];
	logic [$clog2(depth)-1:0] readPtr;
	logic [$clog2(depth)-1:0] writePtr;
	logic [$clog2(depth+1)-1:0] fill;
	logic full;
	logic accept;

	// Wrap a pointer at the end of the buffer.
	function automatic logic [$clog2(depth)-1:0] nextPtr(
		input logic [$clog2(depth)-1:0] ptr
	);
		if (int'(ptr) == depth - 1) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (int'(fill) == depth);
	assign notEmpty = (fill != '0);
	// Writes into a full queue are lost.
	assign accept = write && !full;

	// Head is read straight from storage.
	assign headByte = mem[readPtr];

	always_ff @(posedge clk) begin
		if (accept) begin
			mem[writePtr] <= writeByte;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			readPtr <= '0;
			writePtr <= '0;
			fill <= '0;
			overflow <= 1'b0;
		end else begin
			if (accept) begin
				writePtr <= nextPtr(writePtr);
			end
			if (pop) begin
				readPtr <= nextPtr(readPtr);
			end
			case ({accept, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// Sticky until reset.
			if (write && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// The merger only pops a queue it has seen non-empty.
	popNotEmpty: assert property (@(posedge clk) disable iff (rst)
		pop |-> notEmpty)
		else $error("pop on an empty queue");

endmodule

`default_nettype wire

//--- uartRx/uartRx.sv
`timescale 1ns/10ps
`default_nettype none

module uartRx (
	input wire clk,
	input wire rst,
	// Clock cycles per bit minus one.
	input wire [uartPkg::CLOCK_SCALE_BITS-1:0] cyclesPerBit,
	input wire rx,
	output uartPkg::rxByte_t rxByte,
	output logic byteValid
);
	import uartPkg::*;

	// Receiver phases.
	typedef enum logic [2:0] {
		stateIdle,
		stateStartCheck,
		stateData,
		stateStop,
		stateWaitHigh
	} rxState_t;

	rxState_t state;
	logic [CLOCK_SCALE_BITS-1:0] delayCount;
	logic [CLOCK_SCALE_BITS-1:0] halfBit;
	logic [$clog2(DATA_BITS)-1:0] bitCount;
	logic [DATA_BITS-1:0] shiftReg;
	logic [1:0] rxSync;
	logic rxLine;
	logic halfDone;
	logic fullDone;
	logic sampleData;
	logic sampleStop;

	//////////////////////////////////////////////////
	// Line synchronizer.
	//////////////////////////////////////////////////

	// Two flops, idle line is high.
	always_ff @(posedge clk) begin
		if (rst) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], rx};
		end
	end

	assign rxLine = rxSync[1];

	// Half a bit lands on the middle of the start bit.
	assign halfBit = cyclesPerBit >> 1;
	assign halfDone = (delayCount == halfBit);
	// A full bit is cyclesPerBit + 1 clocks.
	assign fullDone = (delayCount == cyclesPerBit);

	assign sampleData = (state == stateData) && fullDone;
	assign sampleStop = (state == stateStop) && fullDone;

	//////////////////////////////////////////////////
	// Frame FSM.
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			delayCount <= '0;
			bitCount <= '0;
			byteValid <= 1'b0;
		end else begin
			byteValid <= 1'b0;
			case (state)
				stateIdle: begin
					delayCount <= '0;
					bitCount <= '0;
					// Falling edge starts a frame.
					if (!rxLine) begin
						state <= stateStartCheck;
					end
				end
				stateStartCheck: begin
					if (halfDone) begin
						delayCount <= '0;
						// Line back high at mid start bit is a glitch.
						state <= rxLine ? stateIdle : stateData;
					end else begin
						delayCount <= delayCount + 1'b1;
					end
				end
				stateData: begin
					if (fullDone) begin
						delayCount <= '0;
						bitCount <= bitCount + 1'b1;
						if (int'(bitCount) == DATA_BITS - 1) begin
							state <= stateStop;
						end
					end else begin
						delayCount <= delayCount + 1'b1;
					end
				end
				stateStop: begin
					if (fullDone) begin
						delayCount <= '0;
						byteValid <= 1'b1;
						state <= stateWaitHigh;
					end else begin
						delayCount <= delayCount + 1'b1;
					end
				end
				stateWaitHigh: begin
					// A low stop bit keeps us here until the line recovers.
					if (rxLine) begin
						state <= stateIdle;
					end
				end
				default: begin
					state <= stateIdle;
				end
			endcase
		end
	end

	// Data shifts in LSB first, stop bit judged at its middle.
	always_ff @(posedge clk) begin
		if (sampleData) begin
			shiftReg <= {rxLine, shiftReg[DATA_BITS-1:1]};
		end
		if (sampleStop) begin
			rxByte.data <= shiftReg;
			rxByte.framingError <= !rxLine;
		end
	end

endmodule

`default_nettype wire

//--- common/uartPkg.sv
`default_nettype none

package uartPkg;

	//////////////////////////////////////////////////
	// Bit timing and frame format.
	//////////////////////////////////////////////////

	// Width of cyclesPerBit and the bit timing counters.
	localparam int CLOCK_SCALE_BITS = 16;

	// Data bits per frame, 8N1 only.
	localparam int DATA_BITS = 8;

	//////////////////////////////////////////////////
	// Hub sizing.
	//////////////////////////////////////////////////

	// Serial inputs feeding the hub.
	localparam int NUM_CHANNELS = 2;

	// Default entries per channel queue.
	localparam int FIFO_DEPTH = 4;

	// Credits held by the merger after reset.
	localparam int MAX_CREDITS = 4;
	// Must hold 0 to MAX_CREDITS.
	localparam int CREDIT_BITS = 3;

	// One byte as seen by a receiver.
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic framingError;
	} rxByte_t;

	// One tagged word towards the consumer.
	typedef struct packed {
		logic channel;
		logic [DATA_BITS-1:0] data;
		logic framingError;
	} hubWord_t;

endpackage

`default_nettype wire
